// File: hdl/ising_cfg_pkg.sv
`default_nettype none

package ising_cfg_pkg;

    // Problem size
    localparam int SPIN_COUNT = 16;
    // Rows handled per weight beat
    localparam int PARALLELISM = 2;

    // Signed coupling width
    localparam int J_BIT = 4;
    // Signed bias width
    localparam int H_BIT = 4;
    // Unsigned bias scale width
    localparam int SCALE_BIT = 3;

    // Signed local energy of one row
    // Worst case is 16 * 8 + 8 * 7 = 184, so 10 bits leave margin
    localparam int LOCAL_BIT = 10;
    // Per-beat sum of the parallel rows
    localparam int SUM_BIT = LOCAL_BIT + $clog2(PARALLELISM);
    // Total is kept narrow so that overflow is reachable
    localparam int ENERGY_BIT = 12;

    // Row index width
    localparam int IDX_BIT = $clog2(SPIN_COUNT);

    // Register slices on each input stream
    localparam int PIPE_STAGES = 1;

endpackage

`default_nettype wire

// File: hdl/energy_types_pkg.sv
`default_nettype none

package energy_types_pkg;

    import ising_cfg_pkg::*;

    // One row of J with its bias terms
    // Couplings are little-endian, coupling[0] pairs with spin 0
    typedef struct packed {
        logic [SPIN_COUNT-1:0][J_BIT-1:0] coupling;
        // Signed bias
        logic [H_BIT-1:0]                 h;
        // Unsigned bias scale
        logic [SCALE_BIT-1:0]             scale;
    } row_weight_t;

    // Weight stream payload
    // rows[0] is the row at the current counter value
    typedef struct packed {
        row_weight_t [PARALLELISM-1:0] rows;
    } weight_beat_t;

    // Work item for one execute lane
    typedef struct packed {
        // Spin of the row itself, 1 means sigma = +1
        logic        spin;
        row_weight_t row;
    } row_task_t;

    // Result stream payload
    typedef struct packed {
        // Signed total, wrapped
        logic [ENERGY_BIT-1:0] energy;
        // Sticky over the whole run
        logic                  overflow;
    } energy_out_t;

endpackage

`default_nettype wire

// File: hdl/bp_pipe.sv
`default_nettype none

module bp_pipe #(
    parameter type payload_t = logic,
    parameter int  STAGES    = 1
) (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     valid_i,
    output logic          ready_o,
    input  wire payload_t data_i,
    output logic          valid_o,
    input  wire logic     ready_i,
    output payload_t      data_o
);

    if (STAGES == 0) begin : g_bypass
        // No slices, stream goes straight through
        assign valid_o = valid_i;
        assign ready_o = ready_i;
        assign data_o  = data_i;
    end else begin : g_slices
        // Index 0 is the pipe input, index STAGES the pipe output
        logic [STAGES:0] valid_s;
        logic [STAGES:0] ready_s;
        payload_t        data_s [STAGES+1];

        assign valid_s[0]      = valid_i;
        assign data_s[0]       = data_i;
        assign ready_o         = ready_s[0];
        assign valid_o         = valid_s[STAGES];
        assign data_o          = data_s[STAGES];
        assign ready_s[STAGES] = ready_i;

        for (genvar s = 0; s < STAGES; s++) begin : g_slice
            logic     full_q;
            payload_t data_q;

            // Accept when empty or when the held beat leaves this cycle
            assign ready_s[s] = !full_q || ready_s[s+1];

            always_ff @(posedge clk_i) begin
                if (!rst_n_i) begin
                    full_q <= 1'b0;
                end else if (ready_s[s]) begin
                    full_q <= valid_s[s];
                end
            end

            // Data only moves on a transfer
            always_ff @(posedge clk_i) begin
                if (valid_s[s] && ready_s[s]) begin
                    data_q <= data_s[s];
                end
            end

            assign valid_s[s+1] = full_q;
            assign data_s[s+1]  = data_q;
        end
    end

endmodule

`default_nettype wire

// File: hdl/energy_ctrl.sv
`default_nettype none

module energy_ctrl (
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic cfg_valid_i,
    output logic      cfg_ready_o,
    input  wire logic spin_valid_i,
    output logic      spin_ready_o,
    input  wire logic beat_valid_i,
    output logic      beat_ready_o,
    input  wire logic last_beat_i,
    input  wire logic accum_done_i,
    output logic      energy_valid_o,
    input  wire logic energy_ready_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SPIN,
        ST_BEATS,
        ST_DRAIN,
        ST_OUT
    } state_t;

    state_t state_q;
    state_t state_d;

    // Next phase
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cfg_valid_i) begin
                    state_d = ST_SPIN;
                end
            end
            ST_SPIN: begin
                if (spin_valid_i) begin
                    state_d = ST_BEATS;
                end
            end
            ST_BEATS: begin
                // Leave on the transfer of the final row group
                if (beat_valid_i && last_beat_i) begin
                    state_d = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // Wait for the last sum to land in the total
                if (accum_done_i) begin
                    state_d = ST_OUT;
                end
            end
            ST_OUT: begin
                if (energy_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Each stream is open in exactly one phase
    assign cfg_ready_o    = (state_q == ST_IDLE);
    assign spin_ready_o   = (state_q == ST_SPIN);
    assign beat_ready_o   = (state_q == ST_BEATS);
    assign energy_valid_o = (state_q == ST_OUT);

endmodule

`default_nettype wire

// File: hdl/spin_decoder.sv
`default_nettype none

module spin_decoder (
    input  wire logic                                       clk_i,
    input  wire logic                                       rst_n_i,
    input  wire logic                                       cfg_fire_i,
    input  wire logic [ising_cfg_pkg::IDX_BIT-1:0]          start_idx_i,
    input  wire logic                                       spin_fire_i,
    input  wire logic [ising_cfg_pkg::SPIN_COUNT-1:0]       spin_i,
    input  wire logic                                       beat_fire_i,
    input  wire energy_types_pkg::weight_beat_t             beat_i,
    output logic [ising_cfg_pkg::SPIN_COUNT-1:0]            spins_o,
    output energy_types_pkg::row_task_t [ising_cfg_pkg::PARALLELISM-1:0] tasks_o,
    output logic                                            last_beat_o
);

    import ising_cfg_pkg::*;
    import energy_types_pkg::*;

    logic [IDX_BIT-1:0]     start_q;
    logic [IDX_BIT-1:0]     count_q;
    logic [SPIN_COUNT-1:0]  cache_q;
    logic [PARALLELISM-1:0] cur_spins;

    // Start index and row counter
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            start_q <= '0;
            count_q <= '0;
        end else begin
            if (cfg_fire_i) begin
                start_q <= start_idx_i;
            end
            // New vector restarts the row walk
            if (spin_fire_i) begin
                count_q <= start_q;
            end else if (beat_fire_i) begin
                count_q <= count_q + IDX_BIT'(PARALLELISM);
            end
        end
    end

    // Cached spin vector
    always_ff @(posedge clk_i) begin
        if (spin_fire_i) begin
            cache_q <= spin_i;
        end
    end

    // Little-endian group at the counter
    // Counter stays a multiple of PARALLELISM so the slice is in range
    assign cur_spins = cache_q[count_q +: PARALLELISM];

    // Pair each row of the beat with its own spin
    always_comb begin
        for (int p = 0; p < PARALLELISM; p++) begin
            tasks_o[p].spin = cur_spins[p];
            tasks_o[p].row  = beat_i.rows[p];
        end
    end

    assign spins_o = cache_q;

    // Counter sits on the final row group
    assign last_beat_o = (count_q == IDX_BIT'(SPIN_COUNT - PARALLELISM));

endmodule

`default_nettype wire

// File: hdl/partial_energy_calc.sv
`default_nettype none

module partial_energy_calc (
    input  wire logic                                 clk_i,
    input  wire logic                                 rst_n_i,
    input  wire logic                                 valid_i,
    input  wire logic [ising_cfg_pkg::SPIN_COUNT-1:0] spins_i,
    input  wire energy_types_pkg::row_task_t          task_i,
    output logic [ising_cfg_pkg::LOCAL_BIT-1:0]       energy_o
);

    import ising_cfg_pkg::*;

    logic signed [LOCAL_BIT-1:0] coupling_sum;
    logic signed [LOCAL_BIT-1:0] bias_term;
    logic signed [LOCAL_BIT-1:0] field;
    logic signed [LOCAL_BIT-1:0] local_energy;
    logic signed [LOCAL_BIT-1:0] energy_q;

    always_comb begin
        // Sum of J[r][j] * sigma_j, sigma is +1 or -1
        coupling_sum = '0;
        for (int k = 0; k < SPIN_COUNT; k++) begin
            if (spins_i[k]) begin
                coupling_sum = coupling_sum + LOCAL_BIT'($signed(task_i.row.coupling[k]));
            end else begin
                coupling_sum = coupling_sum - LOCAL_BIT'($signed(task_i.row.coupling[k]));
            end
        end

        // Scale is unsigned, zero-extend before the signed product
        bias_term = $signed(task_i.row.h) * $signed({1'b0, task_i.row.scale});

        field = coupling_sum + bias_term;

        // Row spin of 0 flips the sign
        local_energy = task_i.spin ? field : -field;
    end

    // One register stage, loaded on the beat transfer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            energy_q <= '0;
        end else if (valid_i) begin
            energy_q <= local_energy;
        end
    end

    assign energy_o = energy_q;

endmodule

`default_nettype wire

// File: hdl/energy_accumulator.sv
`default_nettype none

module energy_accumulator (
    input  wire logic                                                        clk_i,
    input  wire logic                                                        rst_n_i,
    input  wire logic                                                        valid_i,
    input  wire logic                                                        last_i,
    input  wire logic [ising_cfg_pkg::PARALLELISM-1:0][ising_cfg_pkg::LOCAL_BIT-1:0] partials_i,
    input  wire logic                                                        clear_i,
    output energy_types_pkg::energy_out_t                                    result_o,
    output logic                                                             done_o
);

    import ising_cfg_pkg::*;

    logic                         valid_q;
    logic                         last_q;
    logic signed [SUM_BIT-1:0]    beat_sum;
    logic signed [ENERGY_BIT:0]   total_next;
    logic                         step_ovf;
    logic signed [ENERGY_BIT-1:0] total_q;
    logic                         overflow_q;
    logic                         done_q;

    always_comb begin
        // Parallel rows of one beat, cannot overflow SUM_BIT
        beat_sum = '0;
        for (int p = 0; p < PARALLELISM; p++) begin
            beat_sum = beat_sum + $signed(partials_i[p]);
        end
        // One guard bit to catch leaving the signed range
        total_next = $signed({total_q[ENERGY_BIT-1], total_q}) + beat_sum;
    end

    assign step_ovf = total_next[ENERGY_BIT] ^ total_next[ENERGY_BIT-1];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q    <= 1'b0;
            last_q     <= 1'b0;
            total_q    <= '0;
            overflow_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            // Line up with the execute register
            valid_q <= valid_i;
            last_q  <= valid_i && last_i;
            done_q  <= 1'b0;
            if (clear_i) begin
                total_q    <= '0;
                overflow_q <= 1'b0;
            end else if (valid_q) begin
                total_q    <= total_next[ENERGY_BIT-1:0];
                overflow_q <= overflow_q | step_ovf;
                // Strobe together with the final total
                done_q     <= last_q;
            end
        end
    end

    assign result_o.energy   = total_q;
    assign result_o.overflow = overflow_q;
    assign done_o            = done_q;

endmodule

`default_nettype wire

// File: hdl/energy_monitor.sv
`default_nettype none

module energy_monitor (
    input  wire logic                                 clk_i,
    input  wire logic                                 rst_n_i,
    input  wire logic                                 config_valid_i,
    input  wire logic [ising_cfg_pkg::IDX_BIT-1:0]    config_idx_i,
    output logic                                      config_ready_o,
    input  wire logic                                 spin_valid_i,
    input  wire logic [ising_cfg_pkg::SPIN_COUNT-1:0] spin_i,
    output logic                                      spin_ready_o,
    input  wire logic                                 weight_valid_i,
    input  wire energy_types_pkg::weight_beat_t       weight_i,
    output logic                                      weight_ready_o,
    output logic                                      energy_valid_o,
    input  wire logic                                 energy_ready_i,
    output energy_types_pkg::energy_out_t             energy_o
);

    import ising_cfg_pkg::*;
    import energy_types_pkg::*;

    // Piped streams
    logic                   cfg_valid;
    logic                   cfg_ready;
    logic [IDX_BIT-1:0]     cfg_idx;
    logic                   spin_valid;
    logic                   spin_ready;
    logic [SPIN_COUNT-1:0]  spin_vec;
    logic                   beat_valid;
    logic                   beat_ready;
    weight_beat_t           beat;

    // Fire terms
    logic cfg_fire;
    logic spin_fire;
    logic beat_fire;
    logic energy_fire;

    // Decode, execute and result wires
    logic                                  last_beat;
    logic                                  accum_done;
    logic [SPIN_COUNT-1:0]                 spins;
    row_task_t [PARALLELISM-1:0]           tasks;
    logic [PARALLELISM-1:0][LOCAL_BIT-1:0] partials;

    assign cfg_fire    = cfg_valid && cfg_ready;
    assign spin_fire   = spin_valid && spin_ready;
    assign beat_fire   = beat_valid && beat_ready;
    assign energy_fire = energy_valid_o && energy_ready_i;

    bp_pipe #(.payload_t(logic [IDX_BIT-1:0]), .STAGES(PIPE_STAGES)) u_cfg_pipe (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .valid_i(config_valid_i), .ready_o(config_ready_o), .data_i(config_idx_i),
        .valid_o(cfg_valid), .ready_i(cfg_ready), .data_o(cfg_idx)
    );

    bp_pipe #(.payload_t(logic [SPIN_COUNT-1:0]), .STAGES(PIPE_STAGES)) u_spin_pipe (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .valid_i(spin_valid_i), .ready_o(spin_ready_o), .data_i(spin_i),
        .valid_o(spin_valid), .ready_i(spin_ready), .data_o(spin_vec)
    );

    bp_pipe #(.payload_t(weight_beat_t), .STAGES(PIPE_STAGES)) u_weight_pipe (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .valid_i(weight_valid_i), .ready_o(weight_ready_o), .data_i(weight_i),
        .valid_o(beat_valid), .ready_i(beat_ready), .data_o(beat)
    );

    // Phase sequencing, owns every ready
    energy_ctrl u_ctrl (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .cfg_valid_i(cfg_valid), .cfg_ready_o(cfg_ready),
        .spin_valid_i(spin_valid), .spin_ready_o(spin_ready),
        .beat_valid_i(beat_valid), .beat_ready_o(beat_ready),
        .last_beat_i(last_beat), .accum_done_i(accum_done),
        .energy_valid_o(energy_valid_o), .energy_ready_i(energy_ready_i)
    );

    // Decode
    spin_decoder u_decoder (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .cfg_fire_i(cfg_fire), .start_idx_i(cfg_idx),
        .spin_fire_i(spin_fire), .spin_i(spin_vec),
        .beat_fire_i(beat_fire), .beat_i(beat),
        .spins_o(spins), .tasks_o(tasks), .last_beat_o(last_beat)
    );

    // Execute, one lane per row of the beat
    for (genvar p = 0; p < PARALLELISM; p++) begin : g_lane
        partial_energy_calc u_calc (
            .clk_i(clk_i), .rst_n_i(rst_n_i),
            .valid_i(beat_fire), .spins_i(spins), .task_i(tasks[p]),
            .energy_o(partials[p])
        );
    end

    // Result, cleared when the host takes the total
    energy_accumulator u_accum (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .valid_i(beat_fire), .last_i(last_beat), .partials_i(partials),
        .clear_i(energy_fire), .result_o(energy_o), .done_o(accum_done)
    );

endmodule

`default_nettype wire

// File: verif/energy_monitor_properties.sv
`default_nettype none

module energy_monitor_properties (
    input  wire logic                           clk_i,
    input  wire logic                           rst_n_i,
    input  wire logic                           last_beat_i,
    input  wire logic                           beat_valid_i,
    input  wire logic                           beat_ready_i,
    input  wire energy_types_pkg::weight_beat_t beat_i,
    input  wire logic                           energy_valid_i,
    input  wire logic                           energy_ready_i,
    input  wire energy_types_pkg::energy_out_t  energy_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Result held under back-pressure
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        energy_valid_i && !energy_ready_i |=> energy_valid_i && $stable(energy_i))
        else $error("energy stream dropped valid or changed payload before transfer");

    // Piped weight beat held until the control takes it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        beat_valid_i && !beat_ready_i |=> beat_valid_i && $stable(beat_i))
        else $error("weight stream dropped valid or changed payload before transfer");

    // Final row group closes the weight stream
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        beat_valid_i && beat_ready_i && last_beat_i |=> !beat_ready_i)
        else $error("weight stream still open after the final row group");

    // No result right after reset
    assert property (@(posedge clk_i) !rst_n_i |=> !energy_valid_i)
        else $error("energy_valid_o high after reset");

endmodule

// Control side ready, counter flag and the piped beat are internal to the top level
bind energy_monitor energy_monitor_properties u_props (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .last_beat_i(last_beat),
    .beat_valid_i(beat_valid),
    .beat_ready_i(beat_ready),
    .beat_i(beat),
    .energy_valid_i(energy_valid_o),
    .energy_ready_i(energy_ready_i),
    .energy_i(energy_o)
);

`default_nettype wire

// File: verif/energy_monitor_tb.sv
`default_nettype none

module energy_monitor_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import ising_cfg_pkg::*;
    import energy_types_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_CASES  = 8;
    // Cycle budget per weight beat, covers pipe fill, drain and stalls
    localparam int BEAT_BOUND     = 24;
    localparam int TIMEOUT_CYCLES = NUM_CASES * SPIN_COUNT * BEAT_BOUND;
    // Signed range of the total
    localparam int E_MAX  = 2 ** (ENERGY_BIT - 1) - 1;
    localparam int E_MIN  = -(2 ** (ENERGY_BIT - 1));
    localparam int E_SPAN = 2 ** ENERGY_BIT;

    localparam logic [1:0] SPIN_ONES  = 2'd0;
    localparam logic [1:0] SPIN_ZEROS = 2'd1;
    localparam logic [1:0] SPIN_RAND  = 2'd2;

    // One row of the stimulus table
    typedef struct packed {
        logic [IDX_BIT-1:0]   start;
        logic [1:0]           spin_mode;
        logic                 j_rand;
        logic [J_BIT-1:0]     j_val;
        logic                 bias_rand;
        logic [H_BIT-1:0]     h_val;
        logic [SCALE_BIT-1:0] scale_val;
        logic [7:0]           stall;
    } case_t;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  config_valid_i;
    logic [IDX_BIT-1:0]    config_idx_i;
    logic                  config_ready_o;
    logic                  spin_valid_i;
    logic [SPIN_COUNT-1:0] spin_i;
    logic                  spin_ready_o;
    logic                  weight_valid_i;
    weight_beat_t          weight_i;
    logic                  weight_ready_o;
    logic                  energy_valid_o;
    logic                  energy_ready_i;
    energy_out_t           energy_o;

    case_t                 cases [NUM_CASES];
    row_weight_t           rows [SPIN_COUNT];
    logic [SPIN_COUNT-1:0] spins;
    logic [31:0]           lfsr_q;
    logic [ENERGY_BIT-1:0] exp_energy;
    logic                  exp_ovf;
    // Next config already sitting in the input pipe
    logic                  cfg_sent;
    int                    errors;
    int                    checks;

    energy_monitor dut_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .config_valid_i(config_valid_i), .config_idx_i(config_idx_i),
        .config_ready_o(config_ready_o),
        .spin_valid_i(spin_valid_i), .spin_i(spin_i), .spin_ready_o(spin_ready_o),
        .weight_valid_i(weight_valid_i), .weight_i(weight_i), .weight_ready_o(weight_ready_o),
        .energy_valid_o(energy_valid_o), .energy_ready_i(energy_ready_i), .energy_o(energy_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int b = 0; b < n; b++) begin
            bits = {bits[30:0], lfsr_q[0]};
            if (lfsr_q[0]) begin
                lfsr_q = (lfsr_q >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_q = lfsr_q >> 1;
            end
        end
        return bits;
    endfunction

    // Start, spins, J mode and value, bias mode, h, scale, output stall
    task automatic load_cases();
        cases[0] = '{4'd0, SPIN_ONES, 1'b0, 4'h1, 1'b0, 4'h1, 3'd1, 8'd0};
        cases[1] = '{4'd0, SPIN_ZEROS, 1'b0, 4'hf, 1'b0, 4'hf, 3'd1, 8'd0};
        cases[2] = '{4'd4, SPIN_RAND, 1'b1, 4'h0, 1'b1, 4'h0, 3'd0, 8'd4};
        cases[3] = '{4'd0, SPIN_RAND, 1'b1, 4'h0, 1'b1, 4'h0, 3'd0, 8'd0};
        // Saturating weights, 16 rows of 161 leave the 12-bit range
        cases[4] = '{4'd0, SPIN_ONES, 1'b0, 4'h7, 1'b0, 4'h7, 3'd7, 8'd3};
        cases[5] = '{4'd8, SPIN_RAND, 1'b1, 4'h0, 1'b1, 4'h0, 3'd0, 8'd2};
        cases[6] = '{4'd14, SPIN_RAND, 1'b1, 4'h0, 1'b1, 4'h0, 3'd0, 8'd5};
        cases[7] = '{4'd2, SPIN_ZEROS, 1'b1, 4'h0, 1'b1, 4'h0, 3'd0, 8'd0};
    endtask

    task automatic build_stimulus(input case_t c);
        case (c.spin_mode)
            SPIN_ONES:  spins = '1;
            SPIN_ZEROS: spins = '0;
            default:    spins = SPIN_COUNT'(take_bits(SPIN_COUNT));
        endcase
        for (int r = 0; r < SPIN_COUNT; r++) begin
            for (int k = 0; k < SPIN_COUNT; k++) begin
                rows[r].coupling[k] = c.j_rand ? J_BIT'(take_bits(J_BIT)) : c.j_val;
            end
            rows[r].h     = c.bias_rand ? H_BIT'(take_bits(H_BIT)) : c.h_val;
            rows[r].scale = c.bias_rand ? SCALE_BIT'(take_bits(SCALE_BIT)) : c.scale_val;
        end
    endtask

    // Reference total, one accumulation step per group of PARALLELISM rows
    task automatic compute_expected(input case_t c);
        int field;
        int beat_sum;
        int total;
        logic ovf;
        total = 0;
        ovf   = 1'b0;
        for (int r = int'(c.start); r < SPIN_COUNT; r += PARALLELISM) begin
            beat_sum = 0;
            for (int p = 0; p < PARALLELISM; p++) begin
                field = int'($signed(rows[r+p].h)) * int'(rows[r+p].scale);
                for (int k = 0; k < SPIN_COUNT; k++) begin
                    field += (spins[k] ? 1 : -1) * int'($signed(rows[r+p].coupling[k]));
                end
                beat_sum += spins[r+p] ? field : -field;
            end
            total = total + beat_sum;
            if (total > E_MAX || total < E_MIN) begin
                ovf = 1'b1;
            end
            total = ((total - E_MIN) & (E_SPAN - 1)) + E_MIN;
        end
        exp_energy = ENERGY_BIT'(total);
        exp_ovf    = ovf;
    endtask

    task automatic send_config(input logic [IDX_BIT-1:0] idx);
        config_valid_i <= 1'b1;
        config_idx_i   <= idx;
        do begin
            @(posedge clk_i);
        end while (!config_ready_o);
        config_valid_i <= 1'b0;
    endtask

    task automatic send_spin(input logic [SPIN_COUNT-1:0] vec);
        spin_valid_i <= 1'b1;
        spin_i       <= vec;
        do begin
            @(posedge clk_i);
        end while (!spin_ready_o);
        spin_valid_i <= 1'b0;
    endtask

    // Back-to-back beats from the start row up
    task automatic send_beats(input case_t c);
        weight_beat_t beat;
        for (int r = int'(c.start); r < SPIN_COUNT; r += PARALLELISM) begin
            for (int p = 0; p < PARALLELISM; p++) begin
                beat.rows[p] = rows[r+p];
            end
            weight_valid_i <= 1'b1;
            weight_i       <= beat;
            do begin
                @(posedge clk_i);
            end while (!weight_ready_o);
        end
        weight_valid_i <= 1'b0;
    endtask

    // Check the total, then stall the output with the next config offered
    task automatic collect_result(input case_t c, input logic has_next,
                                  input logic [IDX_BIT-1:0] next_idx);
        do begin
            @(posedge clk_i);
        end while (!energy_valid_o);
        checks += 2;
        if (energy_o.energy !== exp_energy) begin
            errors++;
            $display("error: energy_o got %h expected %h", energy_o.energy, exp_energy);
        end
        if (energy_o.overflow !== exp_ovf) begin
            errors++;
            $display("error: overflow got %h expected %h", energy_o.overflow, exp_ovf);
        end
        if (has_next && c.stall != 0) begin
            config_valid_i <= 1'b1;
            config_idx_i   <= next_idx;
        end
        for (int s = 0; s < int'(c.stall); s++) begin
            @(posedge clk_i);
            checks++;
            if (!energy_valid_o) begin
                errors++;
                $display("energy_valid_o dropped before the output transfer");
            end
            // Held result must still be the model's total and flag
            if (energy_o !== {exp_energy, exp_ovf}) begin
                errors++;
                $display("error: energy_o got %h expected %h", energy_o, {exp_energy, exp_ovf});
            end
            // Pipe slice takes one config, then the stream must stay closed
            if (config_valid_i) begin
                if (config_ready_o) begin
                    config_valid_i <= 1'b0;
                    cfg_sent = 1'b1;
                end
            end else if (cfg_sent && config_ready_o) begin
                errors++;
                $display("error: config_ready_o got %h expected %h", config_ready_o, 1'b0);
            end
        end
        energy_ready_i <= 1'b1;
        @(posedge clk_i);
        energy_ready_i <= 1'b0;
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout, the DUT did not finish all cases within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        config_valid_i = 1'b0;
        config_idx_i   = '0;
        spin_valid_i   = 1'b0;
        spin_i         = '0;
        weight_valid_i = 1'b0;
        weight_i       = '0;
        energy_ready_i = 1'b0;
        lfsr_q         = 32'h9c89fed2;
        cfg_sent       = 1'b0;
        errors         = 0;
        checks         = 0;
        load_cases();
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        // Idle state after reset
        checks += 3;
        if (energy_valid_o !== 1'b0) begin
            errors++;
            $display("error: energy_valid_o got %h expected %h", energy_valid_o, 1'b0);
        end
        if (energy_o !== '0) begin
            errors++;
            $display("error: energy_o got %h expected %h", energy_o, 13'h0);
        end
        if (config_ready_o !== 1'b1) begin
            errors++;
            $display("error: config_ready_o got %h expected %h", config_ready_o, 1'b1);
        end
        for (int n = 0; n < NUM_CASES; n++) begin
            build_stimulus(cases[n]);
            compute_expected(cases[n]);
            if (!cfg_sent) begin
                send_config(cases[n].start);
            end
            cfg_sent = 1'b0;
            send_spin(spins);
            send_beats(cases[n]);
            collect_result(cases[n], n + 1 < NUM_CASES, cases[(n + 1) % NUM_CASES].start);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/ising_cfg_pkg.sv
hdl/energy_types_pkg.sv
hdl/bp_pipe.sv
hdl/energy_ctrl.sv
hdl/spin_decoder.sv
hdl/partial_energy_calc.sv
hdl/energy_accumulator.sv
hdl/energy_monitor.sv
verif/energy_monitor_properties.sv
verif/energy_monitor_tb.sv
